// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = rider_status_tb
RTL_TOP    = rider_status_top
FILELIST   = all.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
logic/rider_status_pkg.sv
logic/rider_regmap_pkg.sv
logic/soft_error_counter.sv
logic/status_reg_block.sv
logic/status_read_port.sv
logic/rider_status_top.sv
testbench/rider_status_tb.sv

// ==== logic/rider_regmap_pkg.sv ====
package rider_regmap_pkg;

  // Status word addresses, named by what the word holds
  typedef enum logic [4:0] {
    reg_fpga_status             = 5'd0,
    reg_error                   = 5'd1,
    reg_ext_clk_temp            = 5'd2,
    reg_clk_synth               = 5'd3,
    reg_daq_link                = 5'd4,
    reg_ttc_tts                 = 5'd5,
    reg_fsm_state0              = 5'd6,
    reg_fsm_state1              = 5'd7,
    reg_acq                     = 5'd8,
    reg_trig_info               = 5'd9,
    reg_trig_delay              = 5'd10,
    reg_trig_num                = 5'd11,
    reg_trig_ts_lsb             = 5'd12,
    reg_trig_ts_msb             = 5'd13,
    reg_pulse_trig_num          = 5'd14,
    reg_corrupt_thres           = 5'd15,
    reg_corrupt_count           = 5'd16,
    reg_unknown_ttc_thres       = 5'd17,
    reg_unknown_ttc_count       = 5'd18,
    reg_ddr3_ovf_thres          = 5'd19,
    reg_ddr3_ovf_count          = 5'd20,
    reg_bursts_chan0            = 5'd21,
    reg_bursts_chan1            = 5'd22,
    reg_bursts_chan2            = 5'd23,
    reg_bursts_chan3            = 5'd24,
    reg_bursts_chan4            = 5'd25,
    reg_xadc_temp_vccint        = 5'd26,
    reg_xadc_vccaux_vccbram     = 5'd27,
    reg_xadc_alarms             = 5'd28,
    reg_raw_ext_trig_count      = 5'd29,
    reg_pulse_trigs_last_ro     = 5'd30,
    reg_accepted_ext_trig_count = 5'd31
  } status_addr_e;

  // Firmware revision reported in word 0
  localparam logic [7:0] major_rev = 8'd3;
  localparam logic [7:0] minor_rev = 8'd2;
  localparam logic [7:0] patch_rev = 8'd0;

  // Digitizer board flavour
  localparam logic [1:0] board_type = 2'd1;

  // Whole status map, index is the word address
  typedef logic [31:0][31:0] status_words_t;

endpackage

// ==== logic/rider_status_pkg.sv ====
package rider_status_pkg;

  // FPGA configuration and run mode
  typedef struct packed {
    logic is_golden;
    logic prog_chan_done;
    logic async_mode;
    logic cbuf_mode;
  } fpga_status_t;

  // External DAQ clock, clock synthesizer and DAQ link levels
  typedef struct packed {
    logic daq_clk_sel;
    logic daq_clk_en;
    logic adcclk_clkin0_stat;
    logic adcclk_clkin1_stat;
    logic adcclk_stat_ld;
    logic adcclk_stat;
    logic daq_almost_full;
    logic daq_ready;
  } clock_status_t;

  // TTC receiver and TTS output
  typedef struct packed {
    logic [3:0] tts_state;
    logic [5:0] ttc_chan_b_info;
    logic       ttc_ready;
  } ttc_status_t;

  // Current state of each acquisition FSM
  typedef struct packed {
    logic [34:0] cm_state;
    logic [3:0]  ttr_state;
    logic [4:0]  ptr_state;
    logic [3:0]  cac_state;
    logic [3:0]  caca_state;
    logic [3:0]  cacc_state;
    logic [6:0]  tp_state;
  } fsm_state_t;

  // Acquisition setup, one bit per channel where five bits wide
  typedef struct packed {
    logic [4:0] acq_readout_pause;
    logic [4:0] fill_type;
    logic [4:0] chan_en;
    logic       endianness_sel;
    logic [4:0] acq_dones;
    logic       accept_pulse_triggers;
    logic       ttc_accept_pulse_triggers;
    logic       ipb_accept_pulse_triggers;
  } acq_status_t;

  // Trigger FIFOs, settings and counters
  typedef struct packed {
    logic        trig_fifo_full;
    logic        pulse_fifo_full;
    logic        acq_fifo_full;
    logic [2:0]  trig_settings;
    logic [31:0] trig_delay;
    logic [23:0] trig_num;
    logic [43:0] trig_timestamp;
    logic [23:0] pulse_trig_num;
    logic [23:0] pulse_trigs_last_readout;
    logic [31:0] raw_ext_trigger_count;
    logic [31:0] accepted_ext_trigger_count;
  } trig_status_t;

  // Hard errors detected outside this subsystem
  typedef struct packed {
    logic       error_trig_num_from_tt;
    logic       error_trig_type_from_tt;
    logic       error_trig_num_from_cm;
    logic       error_trig_type_from_cm;
    logic       error_pll_unlock;
    logic       error_trig_rate;
    // Warning only
    logic       ddr3_almost_full;
    logic [4:0] chan_error_sn;
    logic [4:0] chan_error_rc;
  } hard_error_t;

  // Temperature sensor and XADC readings
  typedef struct packed {
    logic [11:0] i2c_temp;
    logic [15:0] xadc_temp;
    logic [15:0] xadc_vccint;
    logic [15:0] xadc_vccaux;
    logic [15:0] xadc_vccbram;
    logic        xadc_over_temp;
    logic        xadc_alarm_temp;
    logic        xadc_alarm_vccint;
    logic        xadc_alarm_vccaux;
    logic        xadc_alarm_vccbram;
  } slow_ctrl_t;

  // Bursts stored in DDR3, per channel
  typedef struct packed {
    logic [22:0] stored_bursts_chan4;
    logic [22:0] stored_bursts_chan3;
    logic [22:0] stored_bursts_chan2;
    logic [22:0] stored_bursts_chan1;
    logic [22:0] stored_bursts_chan0;
  } ddr3_bursts_t;

  // Soft-error kinds, also the bit index into the over-threshold flags
  typedef enum logic [1:0] {
    data_corrupt  = 2'd0,
    unknown_ttc   = 2'd1,
    ddr3_overflow = 2'd2
  } soft_err_sel_e;

  // Single-cycle error pulses
  typedef struct packed {
    logic ddr3_ovf_pulse;
    logic unknown_cmd_pulse;
    logic cs_mismatch_pulse;
  } soft_err_pulse_t;

  // Count limits, zero disables the flag
  typedef struct packed {
    logic [31:0] thres_ddr3_overflow;
    logic [31:0] thres_unknown_ttc;
    logic [31:0] thres_data_corrupt;
  } soft_err_thres_t;

endpackage

// ==== logic/rider_status_top.sv ====
`timescale 1ns/1ps

module rider_status_top #(
  parameter int COUNT_WIDTH = 32
) (
  input  logic                              clk,
  input  logic                              rst_n,
  // Board status levels
  input  rider_status_pkg::fpga_status_t    fpga,
  input  rider_status_pkg::clock_status_t   clocks,
  input  rider_status_pkg::ttc_status_t     ttc,
  input  rider_status_pkg::fsm_state_t      fsm,
  input  rider_status_pkg::acq_status_t     acq,
  input  rider_status_pkg::trig_status_t    trig,
  input  rider_status_pkg::hard_error_t     hard_err,
  input  rider_status_pkg::slow_ctrl_t      slow,
  input  rider_status_pkg::ddr3_bursts_t    bursts,
  // Soft-error events and their limits
  input  rider_status_pkg::soft_err_pulse_t soft_err,
  input  rider_status_pkg::soft_err_thres_t thres,
  input  logic                              count_clear,
  // Host read port
  input  logic                              rd_strobe,
  input  rider_regmap_pkg::status_addr_e    rd_addr,
  output logic [31:0]                       rd_data,
  output logic                              rd_ack
);

  import rider_status_pkg::*;
  import rider_regmap_pkg::*;

  logic [COUNT_WIDTH-1:0] corrupt_count;
  logic [COUNT_WIDTH-1:0] unknown_ttc_count;
  logic [COUNT_WIDTH-1:0] ddr3_ovf_count;
  // One flag per soft_err_sel_e kind
  logic [2:0]             over_thres;
  status_words_t          words;

  // Checksum mismatch counter
  soft_error_counter #(
    .COUNT_WIDTH(COUNT_WIDTH)
  ) u_corrupt_cnt (
    .clk       (clk),
    .rst_n     (rst_n),
    .err_pulse (soft_err.cs_mismatch_pulse),
    .clear     (count_clear),
    .thres     (COUNT_WIDTH'(thres.thres_data_corrupt)),
    .count     (corrupt_count),
    .over_thres(over_thres[data_corrupt])
  );

  // Unknown TTC broadcast command counter
  soft_error_counter #(
    .COUNT_WIDTH(COUNT_WIDTH)
  ) u_unknown_ttc_cnt (
    .clk       (clk),
    .rst_n     (rst_n),
    .err_pulse (soft_err.unknown_cmd_pulse),
    .clear     (count_clear),
    .thres     (COUNT_WIDTH'(thres.thres_unknown_ttc)),
    .count     (unknown_ttc_count),
    .over_thres(over_thres[unknown_ttc])
  );

  // DDR3 overflow counter
  soft_error_counter #(
    .COUNT_WIDTH(COUNT_WIDTH)
  ) u_ddr3_ovf_cnt (
    .clk       (clk),
    .rst_n     (rst_n),
    .err_pulse (soft_err.ddr3_ovf_pulse),
    .clear     (count_clear),
    .thres     (COUNT_WIDTH'(thres.thres_ddr3_overflow)),
    .count     (ddr3_ovf_count),
    .over_thres(over_thres[ddr3_overflow])
  );

  // Counts widened to a full status word
  status_reg_block u_status_regs (
    .fpga             (fpga),
    .clocks           (clocks),
    .ttc              (ttc),
    .fsm              (fsm),
    .acq              (acq),
    .trig             (trig),
    .hard_err         (hard_err),
    .slow             (slow),
    .bursts           (bursts),
    .thres            (thres),
    .corrupt_count    (32'(corrupt_count)),
    .unknown_ttc_count(32'(unknown_ttc_count)),
    .ddr3_ovf_count   (32'(ddr3_ovf_count)),
    .over_thres       (over_thres),
    .words            (words)
  );

  status_read_port u_read_port (
    .clk      (clk),
    .rst_n    (rst_n),
    .words    (words),
    .rd_strobe(rd_strobe),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .rd_ack   (rd_ack)
  );

endmodule

// ==== logic/soft_error_counter.sv ====
`timescale 1ns/1ps

module soft_error_counter #(
  parameter int COUNT_WIDTH = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // One-cycle event to count
  input  logic                   err_pulse,
  // Level that clears the count while high
  input  logic                   clear,
  input  logic [COUNT_WIDTH-1:0] thres,
  output logic [COUNT_WIDTH-1:0] count,
  output logic                   over_thres
);

  logic [COUNT_WIDTH-1:0] count_next;
  logic                   count_at_max;
  logic                   thres_en;

  // All ones means saturated
  assign count_at_max = &count;

  // Zero threshold turns the flag off
  assign thres_en = |thres;

  // Clear has priority over a pulse in the same cycle
  always_comb begin
    count_next = count;
    if (clear) begin
      count_next = '0;
    end else if (err_pulse && !count_at_max) begin
      count_next = count + COUNT_WIDTH'(1'b1);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count      <= '0;
      over_thres <= 1'b0;
    end else begin
      count      <= count_next;
      // Compare against the next count so the flag moves with the count
      over_thres <= thres_en && (count_next >= thres);
    end
  end

endmodule

// ==== logic/status_read_port.sv ====
`timescale 1ns/1ps

module status_read_port (
  input  logic                            clk,
  input  logic                            rst_n,
  // Live status map from the packing block
  input  rider_regmap_pkg::status_words_t words,
  // Single-cycle read request
  input  logic                            rd_strobe,
  input  rider_regmap_pkg::status_addr_e  rd_addr,
  output logic [31:0]                     rd_data,
  output logic                            rd_ack
);

  logic [31:0] sel_word;

  // Word select straight off the address
  assign sel_word = words[rd_addr];

  // Data is captured on the strobe edge and held until the next strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_data <= '0;
    end else if (rd_strobe) begin
      rd_data <= sel_word;
    end
  end

  // One acknowledge per strobe, one cycle later
  // No back-pressure, a strobe every cycle gives an ack every cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ack <= 1'b0;
    end else begin
      rd_ack <= rd_strobe;
    end
  end

endmodule

// ==== logic/status_reg_block.sv ====
`timescale 1ns/1ps

module status_reg_block (
  input  rider_status_pkg::fpga_status_t    fpga,
  input  rider_status_pkg::clock_status_t   clocks,
  input  rider_status_pkg::ttc_status_t     ttc,
  input  rider_status_pkg::fsm_state_t      fsm,
  input  rider_status_pkg::acq_status_t     acq,
  input  rider_status_pkg::trig_status_t    trig,
  input  rider_status_pkg::hard_error_t     hard_err,
  input  rider_status_pkg::slow_ctrl_t      slow,
  input  rider_status_pkg::ddr3_bursts_t    bursts,
  input  rider_status_pkg::soft_err_thres_t thres,
  input  logic [31:0]                       corrupt_count,
  input  logic [31:0]                       unknown_ttc_count,
  input  logic [31:0]                       ddr3_ovf_count,
  // Indexed by soft_err_sel_e
  input  logic [2:0]                        over_thres,
  output rider_regmap_pkg::status_words_t   words
);

  import rider_status_pkg::*;
  import rider_regmap_pkg::*;

  always_comb begin
    // FPGA mode, board type, then major.minor.patch
    words[reg_fpga_status] = {fpga.is_golden, fpga.prog_chan_done, fpga.async_mode,
                              fpga.cbuf_mode, 2'd0, board_type,
                              major_rev, minor_rev, patch_rev};

    // Errors, soft-error flags come from the local counters
    words[reg_error] = {10'd0, over_thres[ddr3_overflow], 2'd0, hard_err.ddr3_almost_full,
                        hard_err.chan_error_rc, hard_err.chan_error_sn,
                        hard_err.error_trig_type_from_cm, hard_err.error_trig_type_from_tt,
                        hard_err.error_trig_num_from_cm, hard_err.error_trig_num_from_tt,
                        over_thres[data_corrupt], hard_err.error_trig_rate,
                        over_thres[unknown_ttc], hard_err.error_pll_unlock};

    // External clock select and board temperature
    words[reg_ext_clk_temp] = {slow.i2c_temp, 18'd0, clocks.daq_clk_sel, clocks.daq_clk_en};

    // Clock synthesizer
    words[reg_clk_synth] = {28'd0, clocks.adcclk_clkin1_stat, clocks.adcclk_clkin0_stat,
                            clocks.adcclk_stat_ld, clocks.adcclk_stat};

    words[reg_daq_link] = {30'd0, clocks.daq_almost_full, clocks.daq_ready};

    words[reg_ttc_tts] = {21'd0, ttc.tts_state, ttc.ttc_chan_b_info, ttc.ttc_ready};

    // cm_state spills over into the next word
    words[reg_fsm_state0] = fsm.cm_state[31:0];
    // ptr_state is split, its top bit sits above tp_state
    words[reg_fsm_state1] = {fsm.cm_state[34:32], 1'b0, fsm.cacc_state, fsm.ptr_state[4],
                             fsm.tp_state, fsm.caca_state, fsm.cac_state,
                             fsm.ptr_state[3:0], fsm.ttr_state};

    words[reg_acq] = {8'd0, acq.ipb_accept_pulse_triggers, acq.ttc_accept_pulse_triggers,
                      acq.accept_pulse_triggers, acq.acq_dones, acq.endianness_sel,
                      acq.acq_readout_pause, acq.fill_type, acq.chan_en};

    words[reg_trig_info] = {26'd0, trig.pulse_fifo_full, trig.trig_settings,
                            trig.acq_fifo_full, trig.trig_fifo_full};

    // TTC trigger delay, number and 44-bit timestamp
    words[reg_trig_delay]     = trig.trig_delay;
    words[reg_trig_num]       = {8'd0, trig.trig_num};
    words[reg_trig_ts_lsb]    = trig.trig_timestamp[31:0];
    words[reg_trig_ts_msb]    = {20'd0, trig.trig_timestamp[43:32]};
    // Front panel trigger number
    words[reg_pulse_trig_num] = {8'd0, trig.pulse_trig_num};

    // Threshold and count pairs per soft-error kind
    words[reg_corrupt_thres]     = thres.thres_data_corrupt;
    words[reg_corrupt_count]     = corrupt_count;
    words[reg_unknown_ttc_thres] = thres.thres_unknown_ttc;
    words[reg_unknown_ttc_count] = unknown_ttc_count;
    words[reg_ddr3_ovf_thres]    = thres.thres_ddr3_overflow;
    words[reg_ddr3_ovf_count]    = ddr3_ovf_count;

    // Stored DDR3 bursts per channel
    words[reg_bursts_chan0] = {9'd0, bursts.stored_bursts_chan0};
    words[reg_bursts_chan1] = {9'd0, bursts.stored_bursts_chan1};
    words[reg_bursts_chan2] = {9'd0, bursts.stored_bursts_chan2};
    words[reg_bursts_chan3] = {9'd0, bursts.stored_bursts_chan3};
    words[reg_bursts_chan4] = {9'd0, bursts.stored_bursts_chan4};

    // XADC raw readings, two per word
    words[reg_xadc_temp_vccint]    = {slow.xadc_vccint, slow.xadc_temp};
    words[reg_xadc_vccaux_vccbram] = {slow.xadc_vccbram, slow.xadc_vccaux};
    words[reg_xadc_alarms] = {27'd0, slow.xadc_alarm_vccbram, slow.xadc_alarm_vccaux,
                              slow.xadc_alarm_vccint, slow.xadc_alarm_temp,
                              slow.xadc_over_temp};

    // Front panel trigger counters
    words[reg_raw_ext_trig_count]      = trig.raw_ext_trigger_count;
    words[reg_pulse_trigs_last_ro]     = {8'd0, trig.pulse_trigs_last_readout};
    words[reg_accepted_ext_trig_count] = trig.accepted_ext_trigger_count;
  end

endmodule

// ==== testbench/rider_status_tb.sv ====
`timescale 1ns/1ps

module rider_status_tb;

  import rider_status_pkg::*;
  import rider_regmap_pkg::*;

  localparam int          NUM_ROWS      = 8;
  localparam int          READS_PER_ROW = 32;
  localparam int unsigned CYCLE_LIMIT   = NUM_ROWS * READS_PER_ROW * 4 + 100;
  localparam logic [31:0] SEED          = 32'h818fa69d;

  // Read masks with one bit per word address
  localparam logic [31:0] ALL_WORDS   = 32'hffff_ffff;
  localparam logic [31:0] COUNT_WORDS = 32'h001f_8002;
  localparam logic [31:0] CLEAR_WORDS = 32'h0015_0002;

  // One table row with exp_flags indexed by soft_err_sel_e
  typedef struct packed {
    logic        rand_status;
    logic        clear;
    logic [31:0] n_corrupt;
    logic [31:0] n_unknown;
    logic [31:0] n_ovf;
    logic [31:0] thres_corrupt;
    logic [31:0] thres_unknown;
    logic [31:0] thres_ovf;
    logic [2:0]  exp_flags;
    logic [31:0] read_mask;
  } stim_row_t;

  logic            clk;
  logic            rst_n;
  fpga_status_t    fpga;
  clock_status_t   clocks;
  ttc_status_t     ttc;
  fsm_state_t      fsm;
  acq_status_t     acq;
  trig_status_t    trig;
  hard_error_t     hard_err;
  slow_ctrl_t      slow;
  ddr3_bursts_t    bursts;
  soft_err_pulse_t soft_err;
  soft_err_thres_t thres;
  logic            count_clear;
  logic            rd_strobe;
  status_addr_e    rd_addr;
  logic [31:0]     rd_data;
  logic            rd_ack;

  stim_row_t   rows [NUM_ROWS];
  // Reference counts and the flags the current row expects
  logic [31:0] model_count [3];
  logic [2:0]  exp_flags;
  int unsigned cycles = 0;

  rider_status_top #(
    .COUNT_WIDTH(32)
  ) DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .fpga       (fpga),
    .clocks     (clocks),
    .ttc        (ttc),
    .fsm        (fsm),
    .acq        (acq),
    .trig       (trig),
    .hard_err   (hard_err),
    .slow       (slow),
    .bursts     (bursts),
    .soft_err   (soft_err),
    .thres      (thres),
    .count_clear(count_clear),
    .rd_strobe  (rd_strobe),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .rd_ack     (rd_ack)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run length guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      abort_run("Timeout, the stimulus table did not finish within the cycle limit");
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_word(input status_addr_e addr, input logic [31:0] exp);
    if (rd_data !== exp) begin
      $display("** Error: rd_data for %s got 0x%08h expected 0x%08h",
               addr.name(), rd_data, exp);
      abort_run("Read data mismatch");
    end
  endtask

  task automatic check_ack(input logic exp);
    if (rd_ack !== exp) begin
      $display("** Error: rd_ack got 0x%0h expected 0x%0h", rd_ack, exp);
      abort_run("Acknowledge missing or out of place");
    end
  endtask

  function automatic logic [255:0] random_vector();
    logic [255:0] v;
    for (int i = 0; i < 8; i++) begin
      v[i*32 +: 32] = $urandom;
    end
    return v;
  endfunction

  // Counter rule that stops at all ones
  function automatic logic [31:0] sat_add(input logic [31:0] c, input logic [31:0] n);
    logic [32:0] s;
    s = {1'b0, c} + {1'b0, n};
    return s[32] ? 32'hffff_ffff : s[31:0];
  endfunction

  // Zero limit disables the flag
  function automatic logic flag_model(input logic [31:0] cnt, input logic [31:0] limit);
    return (limit != 32'd0) && (cnt >= limit);
  endfunction

  // Reference packing with bit positions from the register map
  function automatic logic [31:0] expected_word(input status_addr_e addr);
    logic [31:0] w;
    w = '0;
    case (addr)
      reg_fpga_status: begin
        w[31:28] = {fpga.is_golden, fpga.prog_chan_done, fpga.async_mode, fpga.cbuf_mode};
        w[25:24] = board_type;
        w[23:0]  = {major_rev, minor_rev, patch_rev};
      end
      reg_error: begin
        w[0]     = hard_err.error_pll_unlock;
        w[1]     = exp_flags[unknown_ttc];
        w[2]     = hard_err.error_trig_rate;
        w[3]     = exp_flags[data_corrupt];
        w[4]     = hard_err.error_trig_num_from_tt;
        w[5]     = hard_err.error_trig_num_from_cm;
        w[6]     = hard_err.error_trig_type_from_tt;
        w[7]     = hard_err.error_trig_type_from_cm;
        w[12:8]  = hard_err.chan_error_sn;
        w[17:13] = hard_err.chan_error_rc;
        w[18]    = hard_err.ddr3_almost_full;
        w[21]    = exp_flags[ddr3_overflow];
      end
      reg_ext_clk_temp: begin
        w[31:20] = slow.i2c_temp;
        w[1:0]   = {clocks.daq_clk_sel, clocks.daq_clk_en};
      end
      reg_clk_synth: begin
        w[3:2] = {clocks.adcclk_clkin1_stat, clocks.adcclk_clkin0_stat};
        w[1:0] = {clocks.adcclk_stat_ld, clocks.adcclk_stat};
      end
      reg_daq_link: w[1:0] = {clocks.daq_almost_full, clocks.daq_ready};
      reg_ttc_tts: w[10:0] = {ttc.tts_state, ttc.ttc_chan_b_info, ttc.ttc_ready};
      reg_fsm_state0: w = fsm.cm_state[31:0];
      reg_fsm_state1: begin
        // Bit 28 stays empty
        w[31:29] = fsm.cm_state[34:32];
        w[27:24] = fsm.cacc_state;
        w[23]    = fsm.ptr_state[4];
        w[22:16] = fsm.tp_state;
        w[15:12] = fsm.caca_state;
        w[11:8]  = fsm.cac_state;
        w[7:4]   = fsm.ptr_state[3:0];
        w[3:0]   = fsm.ttr_state;
      end
      reg_acq: begin
        w[4:0]   = acq.chan_en;
        w[9:5]   = acq.fill_type;
        w[14:10] = acq.acq_readout_pause;
        w[15]    = acq.endianness_sel;
        w[20:16] = acq.acq_dones;
        w[23:21] = {acq.ipb_accept_pulse_triggers, acq.ttc_accept_pulse_triggers,
                    acq.accept_pulse_triggers};
      end
      reg_trig_info: begin
        w[1:0] = {trig.acq_fifo_full, trig.trig_fifo_full};
        w[4:2] = trig.trig_settings;
        w[5]   = trig.pulse_fifo_full;
      end
      reg_trig_delay:              w = trig.trig_delay;
      reg_trig_num:                w[23:0] = trig.trig_num;
      reg_trig_ts_lsb:             w = trig.trig_timestamp[31:0];
      reg_trig_ts_msb:             w[11:0] = trig.trig_timestamp[43:32];
      reg_pulse_trig_num:          w[23:0] = trig.pulse_trig_num;
      reg_corrupt_thres:           w = thres.thres_data_corrupt;
      reg_corrupt_count:           w = model_count[data_corrupt];
      reg_unknown_ttc_thres:       w = thres.thres_unknown_ttc;
      reg_unknown_ttc_count:       w = model_count[unknown_ttc];
      reg_ddr3_ovf_thres:          w = thres.thres_ddr3_overflow;
      reg_ddr3_ovf_count:          w = model_count[ddr3_overflow];
      reg_bursts_chan0:            w[22:0] = bursts.stored_bursts_chan0;
      reg_bursts_chan1:            w[22:0] = bursts.stored_bursts_chan1;
      reg_bursts_chan2:            w[22:0] = bursts.stored_bursts_chan2;
      reg_bursts_chan3:            w[22:0] = bursts.stored_bursts_chan3;
      reg_bursts_chan4:            w[22:0] = bursts.stored_bursts_chan4;
      reg_xadc_temp_vccint:        w = {slow.xadc_vccint, slow.xadc_temp};
      reg_xadc_vccaux_vccbram:     w = {slow.xadc_vccbram, slow.xadc_vccaux};
      reg_xadc_alarms: begin
        w[1:0] = {slow.xadc_alarm_temp, slow.xadc_over_temp};
        w[4:2] = {slow.xadc_alarm_vccbram, slow.xadc_alarm_vccaux, slow.xadc_alarm_vccint};
      end
      reg_raw_ext_trig_count:      w = trig.raw_ext_trigger_count;
      reg_pulse_trigs_last_ro:     w[23:0] = trig.pulse_trigs_last_readout;
      reg_accepted_ext_trig_count: w = trig.accepted_ext_trigger_count;
      default:                     w = '0;
    endcase
    return w;
  endfunction

  // Fresh random levels on every status group
  task automatic randomize_status();
    logic [255:0] r;
    r = random_vector();
    fpga <= r[$bits(fpga_status_t)-1:0];
    r = random_vector();
    clocks <= r[$bits(clock_status_t)-1:0];
    r = random_vector();
    ttc <= r[$bits(ttc_status_t)-1:0];
    r = random_vector();
    fsm <= r[$bits(fsm_state_t)-1:0];
    r = random_vector();
    acq <= r[$bits(acq_status_t)-1:0];
    r = random_vector();
    trig <= r[$bits(trig_status_t)-1:0];
    r = random_vector();
    hard_err <= r[$bits(hard_error_t)-1:0];
    r = random_vector();
    slow <= r[$bits(slow_ctrl_t)-1:0];
    r = random_vector();
    bursts <= r[$bits(ddr3_bursts_t)-1:0];
  endtask

  task automatic zero_status();
    fpga     <= '0;
    clocks   <= '0;
    ttc      <= '0;
    fsm      <= '0;
    acq      <= '0;
    trig     <= '0;
    hard_err <= '0;
    slow     <= '0;
    bursts   <= '0;
  endtask

  // Status, pulses per kind, clear, limits, expected flags, words to read
  task automatic load_table();
    rows[0] = '{1'b0, 1'b0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 3'b000, ALL_WORDS};
    rows[1] = '{1'b1, 1'b0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 3'b000, ALL_WORDS};
    // Zero limits never raise a flag
    rows[2] = '{1'b1, 1'b0, 32'd3, 32'd5, 32'd2, 32'd0, 32'd0, 32'd0, 3'b000, COUNT_WORDS};
    // Counts land exactly on the limits
    rows[3] = '{1'b1, 1'b0, 32'd1, 32'd0, 32'd4, 32'd4, 32'd5, 32'd6, 3'b111, COUNT_WORDS};
    rows[4] = '{1'b1, 1'b0, 32'd2, 32'd2, 32'd2, 32'd4, 32'd5, 32'd6, 3'b111, COUNT_WORDS};
    rows[5] = '{1'b1, 1'b1, 32'd0, 32'd0, 32'd0, 32'd4, 32'd5, 32'd6, 3'b000, CLEAR_WORDS};
    rows[6] = '{1'b1, 1'b1, 32'd3, 32'd1, 32'd7, 32'd3, 32'd2, 32'd7, 3'b101, ALL_WORDS};
    rows[7] = '{1'b1, 1'b0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 3'b000, ALL_WORDS};
  endtask

  task automatic apply_row(input stim_row_t r);
    status_addr_e q[$];
    logic [5:0]   a;
    logic [2:0]   model_flags;
    int           n_max;
    n_max = r.n_corrupt;
    if (r.n_unknown > n_max) n_max = r.n_unknown;
    if (r.n_ovf > n_max) n_max = r.n_ovf;

    @(posedge clk);
    if (r.rand_status) randomize_status();
    else zero_status();
    thres.thres_data_corrupt  <= r.thres_corrupt;
    thres.thres_unknown_ttc   <= r.thres_unknown;
    thres.thres_ddr3_overflow <= r.thres_ovf;

    // Pulses during the clear cycle must be lost
    if (r.clear) begin
      @(posedge clk);
      count_clear <= 1'b1;
      soft_err    <= '1;
      @(posedge clk);
      count_clear <= 1'b0;
      soft_err    <= '0;
      foreach (model_count[k]) model_count[k] = '0;
    end

    for (int i = 0; i < n_max; i++) begin
      @(posedge clk);
      soft_err.cs_mismatch_pulse <= (i < r.n_corrupt);
      soft_err.unknown_cmd_pulse <= (i < r.n_unknown);
      soft_err.ddr3_ovf_pulse    <= (i < r.n_ovf);
    end
    @(posedge clk);
    soft_err <= '0;
    model_count[data_corrupt]  = sat_add(model_count[data_corrupt], r.n_corrupt);
    model_count[unknown_ttc]   = sat_add(model_count[unknown_ttc], r.n_unknown);
    model_count[ddr3_overflow] = sat_add(model_count[ddr3_overflow], r.n_ovf);

    // Table flags must agree with the counter rule
    model_flags[data_corrupt]  = flag_model(model_count[data_corrupt], r.thres_corrupt);
    model_flags[unknown_ttc]   = flag_model(model_count[unknown_ttc], r.thres_unknown);
    model_flags[ddr3_overflow] = flag_model(model_count[ddr3_overflow], r.thres_ovf);
    if (model_flags !== r.exp_flags) begin
      abort_run("Stimulus table flags disagree with the counter model");
    end
    exp_flags = r.exp_flags;

    for (a = 6'd0; a < 6'd32; a++) begin
      if (r.read_mask[a[4:0]]) q.push_back(status_addr_e'(a[4:0]));
    end

    // Back-to-back strobes with each word checked one cycle after its strobe
    for (int i = 0; i <= q.size(); i++) begin
      @(posedge clk);
      if (i < q.size()) begin
        rd_strobe <= 1'b1;
        rd_addr   <= q[i];
      end else begin
        rd_strobe <= 1'b0;
        // Idle address points at another word so a held word stays visible
        rd_addr   <= (q[i-1] == reg_fpga_status) ? reg_error : reg_fpga_status;
      end
      if (i > 0) begin
        @(negedge clk);
        check_ack(1'b1);
        check_word(q[i-1], expected_word(q[i-1]));
      end
    end
    // Single ack per strobe and data held while the address moves
    @(negedge clk);
    check_ack(1'b0);
    check_word(q[q.size()-1], expected_word(q[q.size()-1]));
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n       = 1'b0;
    fpga        = '0;
    clocks      = '0;
    ttc         = '0;
    fsm         = '0;
    acq         = '0;
    trig        = '0;
    hard_err    = '0;
    slow        = '0;
    bursts      = '0;
    soft_err    = '0;
    thres       = '0;
    count_clear = 1'b0;
    rd_strobe   = 1'b0;
    rd_addr     = reg_fpga_status;
    exp_flags   = '0;
    foreach (model_count[k]) model_count[k] = '0;
    load_table();

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // Read port idle after reset
    @(negedge clk);
    check_ack(1'b0);
    check_word(rd_addr, 32'd0);

    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(rows[i]);
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule
